//--- src.f
hdl/axi_lite_pkg.sv
hdl/mst_ctrl_pkg.sv
hdl/wait_timer.sv
hdl/axi_lite_master_write.sv
hdl/axi_lite_master_read.sv
hdl/axi_lite_master.sv
dv/tb_clock_gen.sv
dv/tb_axi_lite_master.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_axi_lite_master -o sim_tb

out=$(./obj_dir/sim_tb 2>&1) || true
echo "$out"

if echo "$out" | grep -q "TEST RESULT: PASS"; then
    exit 0
else
    exit 1
fi

//--- dv/tb_axi_lite_master.sv
`default_nettype none

module tb_axi_lite_master;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_PAIRS    = 20;
    localparam int WAIT_LIMIT = 200;
    // Start strobe to timeout report.
    localparam int ABORT_LIMIT = int'(mst_ctrl_pkg::TIMEOUT_CYCLES) + 2;

    logic                            clk;
    logic                            arstn;
    logic                            start_write;
    logic                            start_read;
    mst_ctrl_pkg::wr_req_t           wr_req;
    mst_ctrl_pkg::rd_req_t           rd_req;
    mst_ctrl_pkg::cmd_status_t       wr_status;
    mst_ctrl_pkg::cmd_status_t       rd_status;
    logic [axi_lite_pkg::DATA_W-1:0] rd_data;
    axi_lite_pkg::wr_s2m_t           wr_s2m;
    axi_lite_pkg::wr_m2s_t           wr_m2s;
    axi_lite_pkg::rd_s2m_t           rd_s2m;
    axi_lite_pkg::rd_m2s_t           rd_m2s;

    // Slave model state.
    logic [31:0]           mem [0:15];
    logic [31:0]           shadow [0:15];
    axi_lite_pkg::wr_m2s_t prev_wr_m2s;
    axi_lite_pkg::rd_m2s_t prev_rd_m2s;
    logic                  have_aw;
    logic                  have_w;
    logic                  b_pend;
    logic                  have_ar;
    logic [31:0]           aw_addr_s;
    logic [31:0]           w_data_s;
    logic [31:0]           ar_addr_s;
    int                    wr_done_cnt;
    int                    rd_done_cnt;

    // Expected results of the transaction in flight.
    logic        exp_wr_fault;
    logic        exp_wr_to;
    logic        exp_rd_fault;
    logic        exp_rd_to;
    logic [31:0] exp_rd_data;

    logic [31:0] lfsr_state = 32'h8145_8125;

    tb_clock_gen tb_clock_gen_inst (
        .clk   (clk),
        .arstn (arstn)
    );

    axi_lite_master axi_lite_master_inst (
        .clk           (clk),
        .arstn         (arstn),
        .i_start_write (start_write),
        .i_wr_req      (wr_req),
        .o_wr_status   (wr_status),
        .i_start_read  (start_read),
        .i_rd_req      (rd_req),
        .o_rd_status   (rd_status),
        .o_rd_data     (rd_data),
        .i_wr_s2m      (wr_s2m),
        .o_wr_m2s      (wr_m2s),
        .i_rd_s2m      (rd_s2m),
        .o_rd_m2s      (rd_m2s)
    );

    // ------------------------------------------------------------------------
    // Helpers.
    // ------------------------------------------------------------------------

    // Galois LFSR, one step per bit taken.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'hA300_0000;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return r;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    // ------------------------------------------------------------------------
    // Slave model, driven on falling edges.
    // ------------------------------------------------------------------------
    initial begin
        for (int i = 0; i < 16; i++) begin
            // Word index folded into both halves.
            mem[i]    = {16'hC0DE ^ 16'(i * 16'h0111), 16'(i) ^ 16'h5A00};
            shadow[i] = mem[i];
        end
        wr_s2m      = '0;
        rd_s2m      = '0;
        prev_wr_m2s = '0;
        prev_rd_m2s = '0;
        have_aw     = 1'b0;
        have_w      = 1'b0;
        b_pend      = 1'b0;
        have_ar     = 1'b0;
        aw_addr_s   = '0;
        w_data_s    = '0;
        ar_addr_s   = '0;
    end

    always @(negedge clk) begin
        if (!arstn) begin
            wr_s2m  = '0;
            rd_s2m  = '0;
            have_aw = 1'b0;
            have_w  = 1'b0;
            b_pend  = 1'b0;
            have_ar = 1'b0;
        end else begin
            // Transfers at the last rising edge.
            if (prev_wr_m2s.aw_valid && wr_s2m.aw_ready) begin
                have_aw   = 1'b1;
                aw_addr_s = prev_wr_m2s.aw_addr;
            end
            if (prev_wr_m2s.w_valid && wr_s2m.w_ready) begin
                have_w   = 1'b1;
                w_data_s = prev_wr_m2s.w_data;
            end
            if (prev_wr_m2s.b_ready && wr_s2m.b_valid) begin
                wr_s2m.b_valid = 1'b0;
            end
            if (prev_rd_m2s.ar_valid && rd_s2m.ar_ready) begin
                have_ar   = 1'b1;
                ar_addr_s = prev_rd_m2s.ar_addr;
            end
            if (prev_rd_m2s.r_ready && rd_s2m.r_valid) begin
                rd_s2m.r_valid = 1'b0;
            end

            // Commit a complete write; bit 31 is an error slot.
            if (have_aw && have_w) begin
                if (!aw_addr_s[31]) begin
                    mem[aw_addr_s[5:2]] = w_data_s;
                end
                wr_s2m.b_resp = aw_addr_s[31] ? axi_lite_pkg::RESP_SLVERR
                                              : axi_lite_pkg::RESP_OKAY;
                have_aw = 1'b0;
                have_w  = 1'b0;
                b_pend  = 1'b1;
            end
            if (b_pend && (take_bits(1) != 0)) begin
                wr_s2m.b_valid = 1'b1;
                b_pend         = 1'b0;
            end
            if (have_ar && !rd_s2m.r_valid && (take_bits(1) != 0)) begin
                rd_s2m.r_valid = 1'b1;
                rd_s2m.r_data  = ar_addr_s[31] ? 32'h0 : mem[ar_addr_s[5:2]];
                rd_s2m.r_resp  = ar_addr_s[31] ? axi_lite_pkg::RESP_SLVERR
                                               : axi_lite_pkg::RESP_OKAY;
                have_ar        = 1'b0;
            end

            // Random readies; bit 30 is never accepted.
            wr_s2m.aw_ready = !have_aw && !b_pend && !wr_s2m.b_valid
                              && !wr_m2s.aw_addr[30] && (take_bits(1) != 0);
            wr_s2m.w_ready  = !have_w && (take_bits(1) != 0);
            rd_s2m.ar_ready = !have_ar && !rd_s2m.r_valid
                              && !rd_m2s.ar_addr[30] && (take_bits(1) != 0);

            prev_wr_m2s = wr_m2s;
            prev_rd_m2s = rd_m2s;
        end
    end

    // Completions seen on the user side, one per done pulse.
    always @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            wr_done_cnt <= 0;
            rd_done_cnt <= 0;
        end else begin
            if (wr_status.done) begin
                wr_done_cnt <= wr_done_cnt + 1;
            end
            if (rd_status.done) begin
                rd_done_cnt <= rd_done_cnt + 1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Checks.
    // ------------------------------------------------------------------------

    // Reset values.
    assert property (@(posedge clk) !arstn |->
        ({wr_m2s.aw_valid, wr_m2s.w_valid, wr_m2s.b_ready, wr_status,
          rd_m2s.ar_valid, rd_m2s.r_ready, rd_status, rd_data} == '0))
    else report_failure($sformatf("Mismatch at %0t: reset outputs got %b/%h expected 0",
        $time, {wr_m2s.aw_valid, wr_m2s.w_valid, wr_m2s.b_ready, wr_status,
        rd_m2s.ar_valid, rd_m2s.r_ready, rd_status}, rd_data));

    // Status on completion.
    assert property (@(posedge clk) disable iff (!arstn) wr_status.done |->
        (wr_status.fault == exp_wr_fault) && (wr_status.timed_out == exp_wr_to))
    else report_failure($sformatf(
        "Mismatch at %0t: o_wr_status fault/timed_out got %b%b expected %b%b",
        $time, wr_status.fault, wr_status.timed_out, exp_wr_fault, exp_wr_to));

    assert property (@(posedge clk) disable iff (!arstn) rd_status.done |->
        (rd_status.fault == exp_rd_fault) && (rd_status.timed_out == exp_rd_to))
    else report_failure($sformatf(
        "Mismatch at %0t: o_rd_status fault/timed_out got %b%b expected %b%b",
        $time, rd_status.fault, rd_status.timed_out, exp_rd_fault, exp_rd_to));

    assert property (@(posedge clk) disable iff (!arstn)
        rd_status.done && !exp_rd_fault |=> rd_data == exp_rd_data)
    else report_failure($sformatf("Mismatch at %0t: o_rd_data got %h expected %h",
        $time, rd_data, exp_rd_data));

    // Fixed payload fields: unprivileged secure data access, all byte lanes.
    assert property (@(posedge clk) disable iff (!arstn)
        wr_m2s.aw_valid |-> wr_m2s.aw_prot == 3'b000)
    else report_failure($sformatf("Mismatch at %0t: aw_prot got %b expected %b",
        $time, wr_m2s.aw_prot, 3'b000));

    assert property (@(posedge clk) disable iff (!arstn)
        wr_m2s.w_valid |-> wr_m2s.w_strb == 4'hF)
    else report_failure($sformatf("Mismatch at %0t: w_strb got %h expected %h",
        $time, wr_m2s.w_strb, 4'hF));

    assert property (@(posedge clk) disable iff (!arstn)
        rd_m2s.ar_valid |-> rd_m2s.ar_prot == 3'b000)
    else report_failure($sformatf("Mismatch at %0t: ar_prot got %b expected %b",
        $time, rd_m2s.ar_prot, 3'b000));

    // Valid held with stable payload until ready, or dropped by a timeout.
    assert property (@(posedge clk) disable iff (!arstn)
        wr_m2s.aw_valid && !wr_s2m.aw_ready |=>
        (wr_m2s.aw_valid && $stable(wr_m2s.aw_addr)) || wr_status.timed_out)
    else report_failure("AW valid or address changed before the AW transfer");

    assert property (@(posedge clk) disable iff (!arstn)
        wr_m2s.w_valid && !wr_s2m.w_ready |=>
        (wr_m2s.w_valid && $stable(wr_m2s.w_data)) || wr_status.timed_out)
    else report_failure("W valid or data changed before the W transfer");

    assert property (@(posedge clk) disable iff (!arstn)
        rd_m2s.ar_valid && !rd_s2m.ar_ready |=>
        (rd_m2s.ar_valid && $stable(rd_m2s.ar_addr)) || rd_status.timed_out)
    else report_failure("AR valid or address changed before the AR transfer");

    // Channel order.
    assert property (@(posedge clk) disable iff (!arstn)
        $rose(wr_m2s.w_valid) |-> $past(wr_m2s.aw_valid && wr_s2m.aw_ready))
    else report_failure("W valid raised before the AW transfer");

    assert property (@(posedge clk) disable iff (!arstn)
        $rose(rd_m2s.r_ready) |-> $past(rd_m2s.ar_valid && rd_s2m.ar_ready))
    else report_failure("R ready raised before the AR transfer");

    // ------------------------------------------------------------------------
    // Stimulus.
    // ------------------------------------------------------------------------
    task automatic run_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic fault, input logic to, input int limit);
        int start_cnt;
        int count;
        exp_wr_fault = fault;
        exp_wr_to    = to;
        start_cnt    = wr_done_cnt;
        @(negedge clk);
        wr_req.addr = addr;
        wr_req.data = data;
        start_write = 1'b1;
        @(negedge clk);
        start_write = 1'b0;
        count = 0;
        while ((wr_done_cnt == start_cnt) && (count < limit)) begin
            @(negedge clk);
            count++;
        end
        if (wr_done_cnt == start_cnt) begin
            report_failure($sformatf("Write to %h did not complete in time", addr));
        end
        // Let the status be sampled before the next expectation.
        @(negedge clk);
    endtask

    task automatic run_read(input logic [31:0] addr, input logic [31:0] data,
                            input logic fault, input logic to, input int limit);
        int start_cnt;
        int count;
        exp_rd_fault = fault;
        exp_rd_to    = to;
        exp_rd_data  = data;
        start_cnt    = rd_done_cnt;
        @(negedge clk);
        rd_req.addr = addr;
        start_read  = 1'b1;
        @(negedge clk);
        start_read = 1'b0;
        count = 0;
        while ((rd_done_cnt == start_cnt) && (count < limit)) begin
            @(negedge clk);
            count++;
        end
        if (rd_done_cnt == start_cnt) begin
            report_failure($sformatf("Read from %h did not complete in time", addr));
        end
        @(negedge clk);
    endtask

    initial begin
        logic [31:0] rnd;
        logic [3:0]  idx;
        logic [31:0] addr;
        logic [31:0] data;
        int          count;
        start_write  = 1'b0;
        start_read   = 1'b0;
        wr_req       = '0;
        rd_req       = '0;
        exp_wr_fault = 1'b0;
        exp_wr_to    = 1'b0;
        exp_rd_fault = 1'b0;
        exp_rd_to    = 1'b0;
        exp_rd_data  = '0;

        count = 0;
        while (!arstn && (count < 20)) begin
            @(negedge clk);
            count++;
        end
        if (!arstn) begin
            report_failure("Reset was never released");
        end

        // Write then read back, random slave delays.
        for (int n = 0; n < N_PAIRS; n++) begin
            rnd  = take_bits(4);
            idx  = rnd[3:0];
            rnd  = take_bits(24);
            addr = {2'b00, rnd[23:0], idx, 2'b00};
            data = take_bits(32);
            run_write(addr, data, 1'b0, 1'b0, WAIT_LIMIT);
            shadow[idx] = data;
            run_read(addr, shadow[idx], 1'b0, 1'b0, WAIT_LIMIT);
        end

        // Error slot leaves memory alone.
        rnd  = take_bits(4);
        idx  = rnd[3:0];
        data = take_bits(32);
        run_write(32'h8000_0000 | {26'h0, idx, 2'b00}, data, 1'b1, 1'b0, WAIT_LIMIT);
        run_read(32'h8000_0000 | {26'h0, idx, 2'b00}, 32'h0, 1'b1, 1'b0, WAIT_LIMIT);
        run_read({26'h0, idx, 2'b00}, shadow[idx], 1'b0, 1'b0, WAIT_LIMIT);

        // Unanswered address, then recovery.
        run_write(32'h4000_0000 | {26'h0, idx, 2'b00}, data, 1'b1, 1'b1, ABORT_LIMIT);
        run_write({26'h0, idx, 2'b00}, ~data, 1'b0, 1'b0, WAIT_LIMIT);
        shadow[idx] = ~data;
        run_read(32'h4000_0000 | {26'h0, idx, 2'b00}, 32'h0, 1'b1, 1'b1, ABORT_LIMIT);
        run_read({26'h0, idx, 2'b00}, shadow[idx], 1'b0, 1'b0, WAIT_LIMIT);

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic arstn
);

    timeunit 1ns;
    timeprecision 1ps;

    // 40 ns period.
    localparam int HALF_PERIOD = 20;
    localparam int RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Release on a falling edge, clear of the sampling edge.
    initial begin
        arstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arstn = 1'b1;
    end

endmodule

`default_nettype wire

//--- hdl/axi_lite_master.sv
`default_nettype none

module axi_lite_master (
    // Clock and reset.
    input  logic                            clk,
    input  logic                            arstn,

    // Write command and report.
    input  logic                            i_start_write,
    input  mst_ctrl_pkg::wr_req_t           i_wr_req,
    output mst_ctrl_pkg::cmd_status_t       o_wr_status,

    // Read command and report.
    input  logic                            i_start_read,
    input  mst_ctrl_pkg::rd_req_t           i_rd_req,
    output mst_ctrl_pkg::cmd_status_t       o_rd_status,
    output logic [axi_lite_pkg::DATA_W-1:0] o_rd_data,

    // AXI4-Lite bus.
    input  axi_lite_pkg::wr_s2m_t           i_wr_s2m,
    output axi_lite_pkg::wr_m2s_t           o_wr_m2s,
    input  axi_lite_pkg::rd_s2m_t           i_rd_s2m,
    output axi_lite_pkg::rd_m2s_t           o_rd_m2s
);

    // Write and read paths run independently.
    axi_lite_master_write axi_lite_master_write_inst (
        .clk           (clk),
        .arstn         (arstn),
        .i_start_write (i_start_write),
        .i_wr_req      (i_wr_req),
        .o_wr_status   (o_wr_status),
        .i_wr_s2m      (i_wr_s2m),
        .o_wr_m2s      (o_wr_m2s)
    );

    axi_lite_master_read axi_lite_master_read_inst (
        .clk          (clk),
        .arstn        (arstn),
        .i_start_read (i_start_read),
        .i_rd_req     (i_rd_req),
        .o_rd_status  (o_rd_status),
        .o_rd_data    (o_rd_data),
        .i_rd_s2m     (i_rd_s2m),
        .o_rd_m2s     (o_rd_m2s)
    );

endmodule

`default_nettype wire

//--- hdl/axi_lite_master_read.sv
`default_nettype none

module axi_lite_master_read (
    // Clock and reset.
    input  logic                            clk,
    input  logic                            arstn,

    // User side.
    input  logic                            i_start_read,
    input  mst_ctrl_pkg::rd_req_t           i_rd_req,
    output mst_ctrl_pkg::cmd_status_t       o_rd_status,
    output logic [axi_lite_pkg::DATA_W-1:0] o_rd_data,

    // AXI4-Lite AR and R channels.
    input  axi_lite_pkg::rd_s2m_t           i_rd_s2m,
    output axi_lite_pkg::rd_m2s_t           o_rd_m2s
);

    typedef enum logic [1:0] {
        IDLE = 2'b00,
        ADDR = 2'b01,
        DATA = 2'b10
    } state_t;

    state_t                          state;
    state_t                          state_next;
    logic [axi_lite_pkg::ADDR_W-1:0] addr_q;
    logic                            ar_xfer;
    logic                            r_xfer;
    logic                            expired;
    logic                            abort;
    logic                            timeout_q;

    assign ar_xfer = (state == ADDR) & i_rd_s2m.ar_ready;
    assign r_xfer  = (state == DATA) & i_rd_s2m.r_valid;
    assign abort   = expired & (state != IDLE) & ~(ar_xfer | r_xfer);

    // --------------------------------------------------------------------------
    // FSM.
    // --------------------------------------------------------------------------
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: if (i_start_read) state_next = ADDR;
            ADDR: if (ar_xfer) state_next = DATA;
            DATA: if (r_xfer) state_next = IDLE;
            default: state_next = IDLE;
        endcase
        if (abort) begin
            state_next = IDLE;
        end
    end

    // Address held stable while AR waits.
    always_ff @(posedge clk) begin
        if ((state == IDLE) && i_start_read) begin
            addr_q <= i_rd_req.addr;
        end
    end

    // Read data kept until the next R transfer.
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            o_rd_data <= '0;
            timeout_q <= 1'b0;
        end else begin
            timeout_q <= abort;
            if (r_xfer) begin
                o_rd_data <= i_rd_s2m.r_data;
            end
        end
    end

    wait_timer wait_timer_inst (
        .clk       (clk),
        .arstn     (arstn),
        .i_run     (state != IDLE),
        .i_clear   (state_next != state),
        .o_expired (expired)
    );

    // --------------------------------------------------------------------------
    // Outputs.
    // --------------------------------------------------------------------------
    assign o_rd_m2s.ar_valid = (state == ADDR);
    assign o_rd_m2s.ar_addr  = addr_q;
    assign o_rd_m2s.ar_prot  = axi_lite_pkg::AXI_PROT;
    // R accepted only once AR has gone.
    assign o_rd_m2s.r_ready  = (state == DATA);

    assign o_rd_status.done      = r_xfer | timeout_q;
    assign o_rd_status.fault     = (r_xfer & i_rd_s2m.r_resp[1]) | timeout_q;
    assign o_rd_status.timed_out = timeout_q;

endmodule

`default_nettype wire

//--- hdl/axi_lite_master_write.sv
`default_nettype none

module axi_lite_master_write (
    // Clock and reset.
    input  logic                      clk,
    input  logic                      arstn,

    // User side.
    input  logic                      i_start_write,
    input  mst_ctrl_pkg::wr_req_t     i_wr_req,
    output mst_ctrl_pkg::cmd_status_t o_wr_status,

    // AXI4-Lite AW, W and B channels.
    input  axi_lite_pkg::wr_s2m_t     i_wr_s2m,
    output axi_lite_pkg::wr_m2s_t     o_wr_m2s
);

    // One state per channel handshake.
    typedef enum logic [1:0] {
        IDLE = 2'b00,
        ADDR = 2'b01,
        DATA = 2'b10,
        RESP = 2'b11
    } state_t;

    state_t                          state;
    state_t                          state_next;
    logic [axi_lite_pkg::ADDR_W-1:0] addr_q;
    logic [axi_lite_pkg::DATA_W-1:0] data_q;
    logic                            aw_xfer;
    logic                            w_xfer;
    logic                            b_xfer;
    logic                            expired;
    logic                            abort;
    logic                            timeout_q;

    // Transfers, qualified by the state that owns the valid or ready.
    assign aw_xfer = (state == ADDR) & i_wr_s2m.aw_ready;
    assign w_xfer  = (state == DATA) & i_wr_s2m.w_ready;
    assign b_xfer  = (state == RESP) & i_wr_s2m.b_valid;

    // Watchdog fired and no transfer rescued it this cycle.
    assign abort = expired & (state != IDLE) & ~(aw_xfer | w_xfer | b_xfer);

    // --------------------------------------------------------------------------
    // FSM.
    // --------------------------------------------------------------------------
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: if (i_start_write) state_next = ADDR;
            ADDR: if (aw_xfer) state_next = DATA;
            DATA: if (w_xfer) state_next = RESP;
            RESP: if (b_xfer) state_next = IDLE;
            default: state_next = IDLE;
        endcase
        // Any stuck handshake drops back to idle.
        if (abort) begin
            state_next = IDLE;
        end
    end

    // Command latched once, held for all three phases.
    always_ff @(posedge clk) begin
        if ((state == IDLE) && i_start_write) begin
            addr_q <= i_wr_req.addr;
            data_q <= i_wr_req.data;
        end
    end

    // Timeout report, one cycle after the abort.
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            timeout_q <= 1'b0;
        end else begin
            timeout_q <= abort;
        end
    end

    // Per-state wait counter.
    wait_timer wait_timer_inst (
        .clk       (clk),
        .arstn     (arstn),
        .i_run     (state != IDLE),
        .i_clear   (state_next != state),
        .o_expired (expired)
    );

    // --------------------------------------------------------------------------
    // Outputs.
    // --------------------------------------------------------------------------
    assign o_wr_m2s.aw_valid = (state == ADDR);
    assign o_wr_m2s.aw_addr  = addr_q;
    assign o_wr_m2s.aw_prot  = axi_lite_pkg::AXI_PROT;
    // W only after the AW transfer.
    assign o_wr_m2s.w_valid  = (state == DATA);
    assign o_wr_m2s.w_data   = data_q;
    assign o_wr_m2s.w_strb   = '1;
    assign o_wr_m2s.b_ready  = (state == RESP);

    // SLVERR and DECERR both carry bit 1.
    assign o_wr_status.done      = b_xfer | timeout_q;
    assign o_wr_status.fault     = (b_xfer & i_wr_s2m.b_resp[1]) | timeout_q;
    assign o_wr_status.timed_out = timeout_q;

endmodule

`default_nettype wire

//--- hdl/wait_timer.sv
`default_nettype none

module wait_timer (
    // Clock and reset.
    input  logic clk,
    input  logic arstn,

    // Engine control.
    input  logic i_run,
    input  logic i_clear,

    // Limit reached.
    output logic o_expired
);

    // Cycles spent in the current handshake state.
    logic [mst_ctrl_pkg::TIMER_W-1:0] count;

    // --------------------------------------------------------------------------
    // Saturating up-counter.
    // --------------------------------------------------------------------------
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            count <= '0;
        end else if (i_clear) begin
            // New state, new wait.
            count <= '0;
        end else if (i_run && (count != mst_ctrl_pkg::TIMEOUT_CYCLES)) begin
            count <= count + 1'b1;
        end
    end

    // Stays high until the engine leaves the state.
    assign o_expired = (count == mst_ctrl_pkg::TIMEOUT_CYCLES);

endmodule

`default_nettype wire

//--- hdl/mst_ctrl_pkg.sv
`default_nettype none

package mst_ctrl_pkg;

    // --------------------------------------------------------------------------
    // Handshake watchdog.
    // --------------------------------------------------------------------------

    // Counter wide enough to hold the limit itself.
    localparam int                 TIMER_W        = 6;
    localparam logic [TIMER_W-1:0] TIMEOUT_CYCLES = TIMER_W'(32);

    // --------------------------------------------------------------------------
    // User side of the master.
    // --------------------------------------------------------------------------

    // Single-beat write command.
    typedef struct packed {
        logic [axi_lite_pkg::ADDR_W-1:0] addr;
        logic [axi_lite_pkg::DATA_W-1:0] data;
    } wr_req_t;

    // Single-beat read command.
    typedef struct packed {
        logic [axi_lite_pkg::ADDR_W-1:0] addr;
    } rd_req_t;

    // Completion report, valid while done is high.
    typedef struct packed {
        logic done;
        logic fault;
        logic timed_out;
    } cmd_status_t;

endpackage

`default_nettype wire

//--- hdl/axi_lite_pkg.sv
`default_nettype none

package axi_lite_pkg;

    // --------------------------------------------------------------------------
    // Bus widths.
    // --------------------------------------------------------------------------
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // Unprivileged, secure, data access.
    localparam logic [2:0] AXI_PROT = 3'b000;

    // Response codes on B and R.
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_EXOKAY = 2'b01;
    localparam logic [1:0] RESP_SLVERR = 2'b10;
    localparam logic [1:0] RESP_DECERR = 2'b11;

    // --------------------------------------------------------------------------
    // Channel bundles, split by driving side.
    // --------------------------------------------------------------------------

    // Write path, master to slave.
    typedef struct packed {
        logic              aw_valid;
        logic [ADDR_W-1:0] aw_addr;
        logic [2:0]        aw_prot;
        logic              w_valid;
        logic [DATA_W-1:0] w_data;
        logic [STRB_W-1:0] w_strb;
        logic              b_ready;
    } wr_m2s_t;

    // Write path, slave to master.
    typedef struct packed {
        logic       aw_ready;
        logic       w_ready;
        logic       b_valid;
        logic [1:0] b_resp;
    } wr_s2m_t;

    // Read path, master to slave.
    typedef struct packed {
        logic              ar_valid;
        logic [ADDR_W-1:0] ar_addr;
        logic [2:0]        ar_prot;
        logic              r_ready;
    } rd_m2s_t;

    // Read path, slave to master.
    typedef struct packed {
        logic              ar_ready;
        logic              r_valid;
        logic [DATA_W-1:0] r_data;
        logic [1:0]        r_resp;
    } rd_s2m_t;

endpackage

`default_nettype wire
